// File: source/isa_pkg.sv
package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    localparam opcode_t OP_SPECIAL = 6'b000000;

    // R-type function codes, SPECIAL opcode only
    localparam funct_t FUNC_SLL  = 6'b000000;
    localparam funct_t FUNC_SRL  = 6'b000010;
    localparam funct_t FUNC_SRA  = 6'b000011;
    localparam funct_t FUNC_SLLV = 6'b000100;
    localparam funct_t FUNC_SRLV = 6'b000110;
    localparam funct_t FUNC_SRAV = 6'b000111;
    localparam funct_t FUNC_MOVZ = 6'b001010;
    localparam funct_t FUNC_MOVN = 6'b001011;
    localparam funct_t FUNC_MFHI = 6'b010000;
    localparam funct_t FUNC_MTHI = 6'b010001;
    localparam funct_t FUNC_MFLO = 6'b010010;
    localparam funct_t FUNC_MTLO = 6'b010011;
    localparam funct_t FUNC_DIV  = 6'b011010;
    localparam funct_t FUNC_DIVU = 6'b011011;
    localparam funct_t FUNC_ADD  = 6'b100000;
    localparam funct_t FUNC_ADDU = 6'b100001;
    localparam funct_t FUNC_SUB  = 6'b100010;
    localparam funct_t FUNC_SUBU = 6'b100011;
    localparam funct_t FUNC_AND  = 6'b100100;
    localparam funct_t FUNC_OR   = 6'b100101;
    localparam funct_t FUNC_XOR  = 6'b100110;
    localparam funct_t FUNC_NOR  = 6'b100111;
    localparam funct_t FUNC_SLT  = 6'b101010;
    localparam funct_t FUNC_SLTU = 6'b101011;

endpackage

// File: source/exec_pkg.sv
package exec_pkg;

    localparam int DIV_STEPS = 32;  // One quotient bit per step
    localparam int DIV_CNT_W = $clog2(DIV_STEPS);

    typedef logic [DIV_CNT_W-1:0] div_cnt_t;

    localparam div_cnt_t DIV_LAST = div_cnt_t'(DIV_STEPS - 1);

    typedef enum logic [3:0] {
        ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_MOVN, ALU_MOVZ, ALU_NOP
    } alu_op_t;

    typedef enum logic [1:0] {GPR_SEL_ALU, GPR_SEL_HI, GPR_SEL_LO} gpr_sel_t;
    typedef enum logic {HILO_SEL_GPR, HILO_SEL_DIV} hilo_sel_t;

    typedef struct packed {
        alu_op_t            alu_op;
        isa_pkg::word_t     opr1;
        isa_pkg::word_t     opr2;
        isa_pkg::reg_addr_t waddr;
        logic               gpr_we;
        logic               hi_we;
        logic               lo_we;
        gpr_sel_t           gpr_sel;
        hilo_sel_t          hilo_sel;
        logic               is_div;
        logic               div_signed;
        logic               reserved;
    } dec_ctrl_t;

    // Register file write returned with ack
    typedef struct packed {
        logic               we;
        isa_pkg::reg_addr_t waddr;
        isa_pkg::word_t     wdata;
    } gpr_wr_t;

    typedef enum logic [1:0] {IDLE, EXEC, DIV_WAIT, DONE} ctrl_state_t;

endpackage

// File: source/instr_decoder.sv
`timescale 1ns/100ps

module instr_decoder (
    input  isa_pkg::instr_t     i_instr,
    input  isa_pkg::word_t      i_rs_data,
    input  isa_pkg::word_t      i_rt_data,
    output exec_pkg::dec_ctrl_t o_ctrl
);
    import isa_pkg::*;
    import exec_pkg::*;

    opcode_t    opcode;
    reg_addr_t  rd;
    logic [4:0] shamt;
    funct_t     funct;

    assign opcode = i_instr[31:26];
    assign rd     = i_instr[15:11];
    assign shamt  = i_instr[10:6];
    assign funct  = i_instr[5:0];

    always_comb
    begin
        o_ctrl          = '0;
        o_ctrl.alu_op   = ALU_NOP;
        o_ctrl.opr1     = i_rs_data;  // rs, rt order unless overridden
        o_ctrl.opr2     = i_rt_data;
        o_ctrl.waddr    = rd;
        o_ctrl.gpr_we   = 1'b1;
        o_ctrl.gpr_sel  = GPR_SEL_ALU;
        o_ctrl.hilo_sel = HILO_SEL_GPR;

        if (opcode != OP_SPECIAL)
            o_ctrl.reserved = 1'b1;
        else
        begin
            case (funct)
                FUNC_AND:             o_ctrl.alu_op = ALU_AND;
                FUNC_OR:              o_ctrl.alu_op = ALU_OR;
                FUNC_XOR:             o_ctrl.alu_op = ALU_XOR;
                FUNC_NOR:             o_ctrl.alu_op = ALU_NOR;
                FUNC_ADD, FUNC_ADDU:  o_ctrl.alu_op = ALU_ADD;  // No overflow trap
                FUNC_SUB, FUNC_SUBU:  o_ctrl.alu_op = ALU_SUB;
                FUNC_SLT:             o_ctrl.alu_op = ALU_SLT;
                FUNC_SLTU:            o_ctrl.alu_op = ALU_SLTU;
                FUNC_MOVN:            o_ctrl.alu_op = ALU_MOVN;
                FUNC_MOVZ:            o_ctrl.alu_op = ALU_MOVZ;
                FUNC_MFHI:            o_ctrl.gpr_sel = GPR_SEL_HI;
                FUNC_MFLO:            o_ctrl.gpr_sel = GPR_SEL_LO;
                FUNC_SLL, FUNC_SRL, FUNC_SRA,
                FUNC_SLLV, FUNC_SRLV, FUNC_SRAV:
                begin
                    // Value to shift is rt; funct[2] picks rs over shamt as the amount
                    o_ctrl.opr1 = i_rt_data;
                    o_ctrl.opr2 = funct[2] ? i_rs_data : {27'h0, shamt};
                    case (funct[1:0])
                        2'b00:   o_ctrl.alu_op = ALU_SLL;
                        2'b10:   o_ctrl.alu_op = ALU_SRL;
                        default: o_ctrl.alu_op = ALU_SRA;
                    endcase
                end
                FUNC_MTHI, FUNC_MTLO:
                begin
                    o_ctrl.gpr_we = 1'b0;
                    o_ctrl.hi_we  = (funct == FUNC_MTHI);
                    o_ctrl.lo_we  = (funct == FUNC_MTLO);
                end
                FUNC_DIV, FUNC_DIVU:
                begin
                    o_ctrl.gpr_we     = 1'b0;
                    o_ctrl.hi_we      = 1'b1;
                    o_ctrl.lo_we      = 1'b1;
                    o_ctrl.hilo_sel   = HILO_SEL_DIV;
                    o_ctrl.is_div     = 1'b1;
                    o_ctrl.div_signed = (funct == FUNC_DIV);
                end
                default:              o_ctrl.reserved = 1'b1;
            endcase
        end

        if (o_ctrl.reserved)
        begin
            o_ctrl.gpr_we = 1'b0;
            o_ctrl.hi_we  = 1'b0;
            o_ctrl.lo_we  = 1'b0;
        end
    end

endmodule

// File: source/alu.sv
`timescale 1ns/100ps

module alu (
    input  exec_pkg::alu_op_t i_op,
    input  isa_pkg::word_t    i_opr1,
    input  isa_pkg::word_t    i_opr2,
    output isa_pkg::word_t    o_result,
    output logic              o_cancel
);
    import isa_pkg::*;
    import exec_pkg::*;

    logic [4:0] sh_amt;

    assign sh_amt = i_opr2[4:0];  // Upper bits of the amount are ignored

    always_comb
    begin
        o_result = '0;
        o_cancel = 1'b0;
        case (i_op)
            ALU_AND:  o_result = i_opr1 & i_opr2;
            ALU_OR:   o_result = i_opr1 | i_opr2;
            ALU_XOR:  o_result = i_opr1 ^ i_opr2;
            ALU_NOR:  o_result = ~(i_opr1 | i_opr2);
            ALU_SLL:  o_result = i_opr1 << sh_amt;
            ALU_SRL:  o_result = i_opr1 >> sh_amt;
            ALU_SRA:  o_result = word_t'($signed(i_opr1) >>> sh_amt);
            ALU_ADD:  o_result = i_opr1 + i_opr2;
            ALU_SUB:  o_result = i_opr1 - i_opr2;
            ALU_SLT:  o_result = {31'h0, $signed(i_opr1) < $signed(i_opr2)};
            ALU_SLTU: o_result = {31'h0, i_opr1 < i_opr2};
            // Conditional moves test rt, which sits in opr2
            ALU_MOVN:
            begin
                o_result = i_opr1;
                o_cancel = (i_opr2 == '0);
            end
            ALU_MOVZ:
            begin
                o_result = i_opr1;
                o_cancel = (i_opr2 != '0);
            end
            default:  o_result = '0;
        endcase
    end

endmodule

// File: source/div_unit.sv
`timescale 1ns/100ps

module div_unit (
    input  logic           i_clk,
    input  logic           i_rst,
    input  logic           i_start,
    input  logic           i_signed,
    input  isa_pkg::word_t i_dividend,
    input  isa_pkg::word_t i_divisor,
    output logic           o_done,
    output isa_pkg::word_t o_quotient,
    output isa_pkg::word_t o_remainder
);
    import isa_pkg::*;
    import exec_pkg::*;

    div_cnt_t    step_cnt;
    logic        busy;
    logic        fix;        // Sign fix cycle after the last step
    logic        last_step;
    logic        q_neg;
    logic        r_neg;
    word_t       quo;        // Dividend bits shift out, quotient bits shift in
    word_t       part;       // Partial remainder
    word_t       dvsr;
    logic [32:0] trial;

    function automatic word_t magnitude(input word_t v, input logic sgn);
        return (sgn && v[31]) ? -v : v;
    endfunction

    assign last_step = busy && (step_cnt == DIV_LAST);
    assign trial     = {part, quo[31]} - {1'b0, dvsr};

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            busy     <= 1'b0;
            fix      <= 1'b0;
            o_done   <= 1'b0;
            step_cnt <= '0;
        end
        else
        begin
            fix    <= last_step;
            o_done <= fix;
            if (i_start)
            begin
                busy     <= 1'b1;
                step_cnt <= '0;
            end
            else if (busy)
            begin
                busy     <= !last_step;
                step_cnt <= step_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_start)
        begin
            quo   <= magnitude(i_dividend, i_signed);
            dvsr  <= magnitude(i_divisor, i_signed);
            part  <= '0;
            q_neg <= i_signed && (i_dividend[31] ^ i_divisor[31]);
            r_neg <= i_signed && i_dividend[31];  // Remainder follows the dividend
        end
        else if (busy)
        begin
            // A zero divisor never borrows, so the quotient fills with ones
            if (!trial[32])
            begin
                part <= trial[31:0];
                quo  <= {quo[30:0], 1'b1};
            end
            else
            begin
                part <= {part[30:0], quo[31]};
                quo  <= {quo[30:0], 1'b0};
            end
        end
        if (fix)
        begin
            o_quotient  <= q_neg ? -quo : quo;
            o_remainder <= r_neg ? -part : part;
        end
    end

    assert property (@(posedge i_clk) disable iff (i_rst)
        i_start |-> !(busy || fix || o_done))
        else $error("div_unit: start issued while a division is in progress");

endmodule

// File: source/writeback.sv
`timescale 1ns/100ps

module writeback (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_commit,
    input  exec_pkg::dec_ctrl_t i_ctrl,
    input  isa_pkg::word_t      i_alu_result,
    input  logic                i_alu_cancel,
    input  isa_pkg::word_t      i_quotient,
    input  isa_pkg::word_t      i_remainder,
    output exec_pkg::gpr_wr_t   o_result
);
    import isa_pkg::*;
    import exec_pkg::*;

    word_t     hi_q;
    word_t     lo_q;
    word_t     gpr_data;
    logic      wr_we;
    reg_addr_t wr_addr;
    word_t     wr_data;

    always_comb
    begin
        case (i_ctrl.gpr_sel)
            GPR_SEL_HI: gpr_data = hi_q;
            GPR_SEL_LO: gpr_data = lo_q;
            default:    gpr_data = i_alu_result;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            hi_q  <= '0;
            lo_q  <= '0;
            wr_we <= 1'b0;
        end
        else if (i_commit)
        begin
            // Divide leaves the remainder in HI and the quotient in LO
            if (i_ctrl.hi_we)
                hi_q <= (i_ctrl.hilo_sel == HILO_SEL_DIV) ? i_remainder : i_ctrl.opr1;
            if (i_ctrl.lo_we)
                lo_q <= (i_ctrl.hilo_sel == HILO_SEL_DIV) ? i_quotient : i_ctrl.opr1;
            wr_we <= i_ctrl.gpr_we && !i_alu_cancel;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_commit)
        begin
            wr_addr <= i_ctrl.waddr;
            wr_data <= gpr_data;
        end
    end

    assign o_result = '{we: wr_we, waddr: wr_addr, wdata: wr_data};

endmodule

// File: source/seq_ctrl.sv
`timescale 1ns/100ps

module seq_ctrl (
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_req,
    input  isa_pkg::instr_t i_instr,
    input  isa_pkg::word_t  i_rs_data,
    input  isa_pkg::word_t  i_rt_data,
    input  logic            i_is_div,
    input  logic            i_reserved,
    input  logic            i_div_done,
    output isa_pkg::instr_t o_instr,
    output isa_pkg::word_t  o_rs_data,
    output isa_pkg::word_t  o_rt_data,
    output logic            o_div_start,
    output logic            o_commit,
    output logic            o_ack,
    output logic            o_reserved
);
    import exec_pkg::*;

    ctrl_state_t state;

    assign o_div_start = (state == EXEC) && i_is_div;
    assign o_commit    = ((state == EXEC) && !i_is_div) || ((state == DIV_WAIT) && i_div_done);

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            state      <= IDLE;
            o_ack      <= 1'b0;
            o_reserved <= 1'b0;
        end
        else
        begin
            case (state)
                IDLE:
                    if (i_req)
                        state <= EXEC;
                EXEC:
                    state <= i_is_div ? DIV_WAIT : DONE;
                DIV_WAIT:
                    if (i_div_done)
                        state <= DONE;
                default:
                    if (!i_req)  // Requester released, close the handshake
                    begin
                        state      <= IDLE;
                        o_ack      <= 1'b0;
                        o_reserved <= 1'b0;
                    end
            endcase
            if (o_commit)
            begin
                o_ack      <= 1'b1;
                o_reserved <= i_reserved;
            end
        end
    end

    // Held for the whole transaction
    always_ff @(posedge i_clk)
    begin
        if ((state == IDLE) && i_req)
        begin
            o_instr   <= i_instr;
            o_rs_data <= i_rs_data;
            o_rt_data <= i_rt_data;
        end
    end

    assert property (@(posedge i_clk) disable iff (i_rst) o_ack |-> (state == DONE))
        else $error("seq_ctrl: ack high outside DONE");
    assert property (@(posedge i_clk) disable iff (i_rst) o_commit |=> !o_commit)
        else $error("seq_ctrl: commit held longer than one cycle");

endmodule

// File: source/decode_exec_top.sv
`timescale 1ns/100ps

module decode_exec_top (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_req,
    input  isa_pkg::instr_t   i_instr,
    input  isa_pkg::word_t    i_rs_data,
    input  isa_pkg::word_t    i_rt_data,
    output logic              o_ack,
    output logic              o_reserved,
    output exec_pkg::gpr_wr_t o_result
);
    import isa_pkg::*;
    import exec_pkg::*;

    instr_t    instr_q;
    word_t     rs_q;
    word_t     rt_q;
    dec_ctrl_t ctrl;
    word_t     alu_result;
    logic      alu_cancel;
    logic      div_start;
    logic      div_done;
    word_t     quotient;
    word_t     remainder;
    logic      commit;

    seq_ctrl seq_ctrl_i (
        .i_clk(i_clk), .i_rst(i_rst), .i_req(i_req),
        .i_instr(i_instr), .i_rs_data(i_rs_data), .i_rt_data(i_rt_data),
        .i_is_div(ctrl.is_div), .i_reserved(ctrl.reserved), .i_div_done(div_done),
        .o_instr(instr_q), .o_rs_data(rs_q), .o_rt_data(rt_q),
        .o_div_start(div_start), .o_commit(commit),
        .o_ack(o_ack), .o_reserved(o_reserved)
    );

    instr_decoder instr_decoder_i (
        .i_instr(instr_q), .i_rs_data(rs_q), .i_rt_data(rt_q), .o_ctrl(ctrl)
    );

    alu alu_i (
        .i_op(ctrl.alu_op), .i_opr1(ctrl.opr1), .i_opr2(ctrl.opr2),
        .o_result(alu_result), .o_cancel(alu_cancel)
    );

    div_unit div_unit_i (
        .i_clk(i_clk), .i_rst(i_rst), .i_start(div_start), .i_signed(ctrl.div_signed),
        .i_dividend(ctrl.opr1), .i_divisor(ctrl.opr2),
        .o_done(div_done), .o_quotient(quotient), .o_remainder(remainder)
    );

    writeback writeback_i (
        .i_clk(i_clk), .i_rst(i_rst), .i_commit(commit), .i_ctrl(ctrl),
        .i_alu_result(alu_result), .i_alu_cancel(alu_cancel),
        .i_quotient(quotient), .i_remainder(remainder), .o_result(o_result)
    );

endmodule

// File: dv/tb_decode_exec.sv
`timescale 1ns/100ps

module tb_decode_exec;
    import isa_pkg::*;
    import exec_pkg::*;

    localparam string STIM_FILE = "dv/decode_exec_stimulus.txt";

    typedef struct packed {
        instr_t     instr;
        word_t      rs;
        word_t      rt;
        logic [1:0] kind;   // 0 no write, 1 write, 2 reserved
        reg_addr_t  addr;
        word_t      data;
    } vector_t;

    logic    i_clk;
    logic    i_rst;
    logic    i_req;
    instr_t  i_instr;
    word_t   i_rs_data;
    word_t   i_rt_data;
    logic    o_ack;
    logic    o_reserved;
    gpr_wr_t o_result;

    vector_t vectors[$];
    int      n_vectors = 0;
    int      n_checks = 0;
    int      n_errors = 0;

    decode_exec_top dut_i (
        .i_clk(i_clk), .i_rst(i_rst), .i_req(i_req),
        .i_instr(i_instr), .i_rs_data(i_rs_data), .i_rt_data(i_rt_data),
        .o_ack(o_ack), .o_reserved(o_reserved), .o_result(o_result)
    );

    always #5 i_clk = ~i_clk;

    // Address and data only matter when a write is expected
    task automatic check_wr(input gpr_wr_t act, input gpr_wr_t exp, input int idx);
        n_checks++;
        if (act.we !== exp.we)
        begin
            n_errors++;
            $display("[FAIL] o_result.we got 0x%h expected 0x%h (vector %0d)",
                     act.we, exp.we, idx);
        end
        else if (exp.we)
        begin
            if (act.waddr !== exp.waddr)
            begin
                n_errors++;
                $display("[FAIL] o_result.waddr got 0x%h expected 0x%h (vector %0d)",
                         act.waddr, exp.waddr, idx);
            end
            if (act.wdata !== exp.wdata)
            begin
                n_errors++;
                $display("[FAIL] o_result.wdata got 0x%h expected 0x%h (vector %0d)",
                         act.wdata, exp.wdata, idx);
            end
        end
    endtask

    task automatic check_flag(input string name, input logic act, input logic exp, input int idx);
        n_checks++;
        if (act !== exp)
        begin
            n_errors++;
            $display("[FAIL] %s got 0x%h expected 0x%h (vector %0d)", name, act, exp, idx);
        end
    endtask

    task automatic run_vector(input vector_t v, input int idx);
        gpr_wr_t exp;
        int      extra;
        exp = '{we: (v.kind == 2'd1), waddr: v.addr, wdata: v.data};
        @(negedge i_clk);
        i_instr   = v.instr;
        i_rs_data = v.rs;
        i_rt_data = v.rt;
        i_req     = 1'b1;
        @(negedge i_clk);
        while (!o_ack)
            @(negedge i_clk);
        check_wr(o_result, exp, idx);
        check_flag("o_reserved", o_reserved, v.kind == 2'd2, idx);
        extra = $urandom % 6;  // Back-pressure
        repeat (extra)
        begin
            @(negedge i_clk);
            check_flag("o_ack", o_ack, 1'b1, idx);
            check_flag("o_reserved", o_reserved, v.kind == 2'd2, idx);
            check_wr(o_result, exp, idx);
        end
        i_req = 1'b0;
        @(negedge i_clk);
        check_flag("o_ack", o_ack, 1'b0, idx);  // Drops on the edge that sees req low
        while (o_ack)
            @(negedge i_clk);
    endtask

    initial
    begin
        int          fd;
        string       line;
        vector_t     v;
        logic [31:0] f_instr, f_rs, f_rt, f_kind, f_addr, f_data;
        void'($urandom(32'h9a9b));
        i_clk     = 1'b0;
        i_rst     = 1'b1;
        i_req     = 1'b0;
        i_instr   = '0;
        i_rs_data = '0;
        i_rt_data = '0;

        fd = $fopen(STIM_FILE, "r");
        if (fd != 0)
        begin
            while (!$feof(fd))
            begin
                line = "";
                void'($fgets(line, fd));
                // Comment and blank lines do not scan
                if ($sscanf(line, "%h %h %h %h %h %h",
                            f_instr, f_rs, f_rt, f_kind, f_addr, f_data) == 6)
                begin
                    v = '{instr: f_instr, rs: f_rs, rt: f_rt, kind: f_kind[1:0],
                          addr: f_addr[4:0], data: f_data};
                    vectors.push_back(v);
                end
            end
            $fclose(fd);
        end
        if (vectors.size() == 0)
        begin
            $display("No stimulus vectors could be read from %s", STIM_FILE);
            n_errors++;
        end
        n_vectors = vectors.size();

        repeat (16) @(negedge i_clk);
        i_rst = 1'b0;
        check_flag("o_ack", o_ack, 1'b0, -1);
        check_flag("o_result.we", o_result.we, 1'b0, -1);

        foreach (vectors[i])
            run_vector(vectors[i], i);

        $display("Vectors: %0d, checks: %0d, errors: %0d", n_vectors, n_checks, n_errors);
        if (n_errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

    // Watchdog sized from the vector count, divide latency and reset
    initial
    begin
        wait (n_vectors > 0);
        #((16 + n_vectors * (DIV_STEPS + 10)) * 10);
        $display("Timeout: the DUT stopped completing handshakes");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: dv/decode_exec_stimulus.txt
# instr    rs       rt       kind addr data  (all hex)
# kind 0 = no write, 1 = write, 2 = reserved; addr and data unused unless kind is 1
00221824 F0F01234 0FF0FF00 1 03 00F01200
00223027 F0F00000 0000FFFF 1 06 0F0F0000
00223820 7FFFFFFF 00000001 1 07 80000000
00224023 00000005 00000007 1 08 FFFFFFFE
0022482A FFFFFFFF 00000001 1 09 00000001
0022502B FFFFFFFF 00000001 1 0A 00000000
00221903 00000000 80000010 1 03 F8000001
00222004 00000024 00000003 1 04 00000030
00222806 FFFFFFE8 80000000 1 05 00800000
0022380B CAFEF00D 00000001 1 07 CAFEF00D
0022380B 12345678 00000000 0 00 00000000
0022400A 0BADBEEF 00000000 1 08 0BADBEEF
0022400A DEADBEEF 00000005 0 00 00000000
00200011 11112222 00000000 0 00 00000000
00200013 33334444 00000000 0 00 00000000
00004810 00000000 00000000 1 09 11112222
00005012 00000000 00000000 1 0A 33334444
# DIV -7 / 2, then DIVU of the same operands, then DIV -10 / 0
0022001A FFFFFFF9 00000002 0 00 00000000
00001810 00000000 00000000 1 03 FFFFFFFF
00002012 00000000 00000000 1 04 FFFFFFFD
0022001B FFFFFFF9 00000002 0 00 00000000
00002810 00000000 00000000 1 05 00000001
00003012 00000000 00000000 1 06 7FFFFFFC
0022001A FFFFFFF6 00000000 0 00 00000000
00003810 00000000 00000000 1 07 FFFFFFF6
00004012 00000000 00000000 1 08 00000001
8C220000 00000001 00000002 2 00 00000000
00220018 00000003 00000004 2 00 00000000

// File: list.f
source/isa_pkg.sv
source/exec_pkg.sv
source/instr_decoder.sv
source/alu.sv
source/div_unit.sv
source/writeback.sv
source/seq_ctrl.sv
source/decode_exec_top.sv
dv/tb_decode_exec.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_decode_exec -f list.f --Mdir obj_dir -o sim_decode_exec

./obj_dir/sim_decode_exec > sim.log 2>&1
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi
echo "Simulation finished without failures"
